// File: hw/spif_pkg.sv
/* serial flash loader definitions */
package spif_pkg;

  // ==========================================================================
  // types
  // ==========================================================================
  typedef logic [7:0]  byte_t;             // flash or uart byte
  typedef logic [17:0] word_t;             // data word, WIDTH bits
  typedef logic [15:0] insn_t;             // instruction word
  typedef logic [15:0] boot_addr_t;        // destination or run length
  typedef logic [14:0] io_addr_t;          // processor address
  typedef logic [3:0]  rate_t;             // flash sclk divisor

  typedef enum logic [2:0] {
    BOOT_IDLE,                             // processor owns the block
    BOOT_CLEAR,                            // zeroing both rams
    BOOT_CMD,                              // sending read opcode
    BOOT_ADDR,                             // sending 24-bit address
    BOOT_DUMMY,                            // fast read dummy byte
    BOOT_STREAM                            // interpreting the image
  } boot_state_e;

  typedef enum logic [2:0] {
    MODE_CMD,
    MODE_ADDR_HI,
    MODE_ADDR_LO,
    MODE_LEN_HI,
    MODE_LEN_LO,
    MODE_DATA
  } stream_mode_e;

  // ==========================================================================
  // sizes and constants
  // ==========================================================================
  localparam int CODE_SIZE = 10;           // log2 code words
  localparam int DATA_SIZE = 10;           // log2 data cells
  localparam int WIDTH     = 18;           // data word width

  localparam byte_t BASEBLOCK  = 8'd0;     // first 64k sector of the image
  localparam byte_t FAST_READ  = 8'h0B;
  localparam rate_t RATE_RESET = 4'd7;     // slow sclk until the image says

  // i/o register map, low address nibble
  localparam logic [3:0] REG_UART      = 4'd0;
  localparam logic [3:0] REG_CODE_ADDR = 4'd1;
  localparam logic [3:0] REG_CODE_DATA = 4'd2;
  localparam logic [3:0] REG_REBOOT    = 4'd3;
  localparam logic [3:0] REG_BOOTING   = 4'd5;

endpackage

// File: hw/spram.sv
/* single-port RAM */
module spram #(
  parameter int ADDR_WIDTH = 10,
  parameter int DATA_WIDTH = 16
) (
  input  logic                  clk,
  input  logic [ADDR_WIDTH-1:0] i_addr,
  input  logic [DATA_WIDTH-1:0] i_din,
  input  logic                  i_we,
  input  logic                  i_re,
  output logic [DATA_WIDTH-1:0] o_dout
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_addr] <= i_din;
    end
    if (i_re) begin
      o_dout <= mem[i_addr];               // held while i_re is low
    end
  end

endmodule

// File: hw/boot_ctrl.sv
/* boot control FSM */
module boot_ctrl (
  input  logic            clk,
  input  logic            arstn,
  input  logic            i_f_ready,       // flash engine idle, byte valid
  input  spif_pkg::byte_t i_f_din,
  input  logic            i_run_done,      // last word of a run written
  input  logic            i_reboot,
  output logic            o_f_wr,
  output spif_pkg::byte_t o_f_dout,
  output logic            o_f_cs,
  output spif_pkg::rate_t o_f_rate,
  output logic            o_p_reset,
  output logic            o_booting,
  output logic            o_clear,
  output logic            o_load_addr_hi,
  output logic            o_load_addr_lo,
  output logic            o_load_len_hi,
  output logic            o_load_len_lo,
  output logic            o_load_format,
  output logic            o_shift_byte,
  output logic [2:0]      o_sink           // 0 code, 1 data, else dropped
);

  spif_pkg::boot_state_e          state;
  spif_pkg::stream_mode_e         mode;
  logic [spif_pkg::CODE_SIZE-1:0] clr_cnt;
  logic [1:0]                     hdr_cnt;  // address byte index
  logic                           pending;  // transfer in flight
  logic                           reading;
  logic                           byte_in;
  logic                           stream_byte;

  assign reading = (state == spif_pkg::BOOT_CMD) || (state == spif_pkg::BOOT_ADDR) ||
                   (state == spif_pkg::BOOT_DUMMY) || (state == spif_pkg::BOOT_STREAM);
  assign byte_in     = pending & ~o_f_wr & i_f_ready;  // ready is back
  assign stream_byte = byte_in & (state == spif_pkg::BOOT_STREAM);
  assign o_booting   = (state != spif_pkg::BOOT_IDLE);
  assign o_clear     = (state == spif_pkg::BOOT_CLEAR);

  // ==========================================================================
  // per-byte strobes to the datapath
  // ==========================================================================
  always_comb begin
    o_load_addr_hi = 1'b0;
    o_load_addr_lo = 1'b0;
    o_load_len_hi  = 1'b0;
    o_load_len_lo  = 1'b0;
    o_load_format  = 1'b0;
    o_shift_byte   = 1'b0;
    if (stream_byte) begin
      case (mode)
        spif_pkg::MODE_ADDR_HI: o_load_addr_hi = 1'b1;
        spif_pkg::MODE_ADDR_LO: o_load_addr_lo = 1'b1;
        spif_pkg::MODE_LEN_HI:  o_load_len_hi = 1'b1;
        spif_pkg::MODE_LEN_LO:  o_load_len_lo = 1'b1;
        spif_pkg::MODE_DATA:    o_shift_byte = 1'b1;
        default:                o_load_format = ~i_f_din[7];  // 0x data command
      endcase
    end
  end

  // ==========================================================================
  // sequencer
  // ==========================================================================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      state     <= spif_pkg::BOOT_CLEAR;
      mode      <= spif_pkg::MODE_CMD;
      clr_cnt   <= '0;
      hdr_cnt   <= '0;
      pending   <= 1'b0;
      o_f_wr    <= 1'b0;
      o_f_dout  <= '0;
      o_f_cs    <= 1'b0;
      o_f_rate  <= spif_pkg::RATE_RESET;
      o_p_reset <= 1'b1;
      o_sink    <= '0;
    end else begin
      o_f_wr <= 1'b0;
      if (reading && i_f_ready && !pending && !o_f_wr) begin
        o_f_wr  <= 1'b1;                   // ask for the next byte
        pending <= 1'b1;
        if (state == spif_pkg::BOOT_CMD) begin
          o_f_dout <= spif_pkg::FAST_READ;
        end else if (state == spif_pkg::BOOT_ADDR && hdr_cnt == 2'd0) begin
          o_f_dout <= spif_pkg::BASEBLOCK;
        end else begin
          o_f_dout <= 8'h00;               // low address, dummy, stream
        end
      end
      if (byte_in) begin
        pending <= 1'b0;
      end

      case (state)
        spif_pkg::BOOT_IDLE: begin
          if (i_reboot) begin
            state  <= spif_pkg::BOOT_CMD;
            o_f_cs <= 1'b1;
          end
        end
        spif_pkg::BOOT_CLEAR: begin
          clr_cnt <= clr_cnt + 1'b1;
          if (clr_cnt == '1) begin
            state  <= spif_pkg::BOOT_CMD;
            o_f_cs <= 1'b1;
          end
        end
        spif_pkg::BOOT_CMD: begin
          if (byte_in) state <= spif_pkg::BOOT_ADDR;
        end
        spif_pkg::BOOT_ADDR: begin
          if (byte_in) begin
            hdr_cnt <= hdr_cnt + 2'd1;
            if (hdr_cnt == 2'd2) begin
              hdr_cnt <= '0;
              state   <= spif_pkg::BOOT_DUMMY;
            end
          end
        end
        spif_pkg::BOOT_DUMMY: begin
          if (byte_in) begin
            state <= spif_pkg::BOOT_STREAM;
            mode  <= spif_pkg::MODE_CMD;
          end
        end
        spif_pkg::BOOT_STREAM: begin
          if (stream_byte) begin
            case (mode)
              spif_pkg::MODE_ADDR_HI: mode <= spif_pkg::MODE_ADDR_LO;
              spif_pkg::MODE_LEN_HI:  mode <= spif_pkg::MODE_LEN_LO;
              spif_pkg::MODE_ADDR_LO,
              spif_pkg::MODE_LEN_LO:  mode <= spif_pkg::MODE_CMD;
              spif_pkg::MODE_DATA:    mode <= spif_pkg::MODE_DATA;  // datapath ends it
              default: begin
                if (i_f_din[7:6] == 2'b11) begin
                  if (i_f_din[5]) begin    // end of image
                    o_p_reset <= i_f_din[4];
                    o_f_cs    <= 1'b0;
                    state     <= spif_pkg::BOOT_IDLE;
                  end else if (i_f_din[1]) begin
                    mode <= i_f_din[0] ? spif_pkg::MODE_LEN_HI : spif_pkg::MODE_LEN_LO;
                  end else begin
                    mode <= i_f_din[0] ? spif_pkg::MODE_ADDR_HI : spif_pkg::MODE_ADDR_LO;
                  end
                end else if (i_f_din[7]) begin
                  o_f_rate <= i_f_din[3:0];  // new sclk divisor
                end else begin
                  o_sink <= i_f_din[4:2];
                  mode   <= spif_pkg::MODE_DATA;
                end
              end
            endcase
          end else if (i_run_done) begin
            mode <= spif_pkg::MODE_CMD;    // run finished
          end
        end
        default: state <= spif_pkg::BOOT_IDLE;
      endcase
    end
  end

endmodule

// File: hw/boot_datapath.sv
/* boot datapath and RAM steering */
module boot_datapath (
  input  logic                           clk,
  input  logic                           arstn,
  input  logic                           i_clear,
  input  logic                           i_load_addr_hi,
  input  logic                           i_load_addr_lo,
  input  logic                           i_load_len_hi,
  input  logic                           i_load_len_lo,
  input  logic                           i_load_format,
  input  logic                           i_shift_byte,
  input  spif_pkg::byte_t                i_f_din,
  input  logic [2:0]                     i_sink,
  input  logic                           i_code_addr_wr,
  input  logic                           i_code_data_wr,
  input  spif_pkg::word_t                i_din,
  input  spif_pkg::io_addr_t             i_code_addr,
  input  spif_pkg::io_addr_t             i_mem_addr,
  input  logic                           i_mem_wr,
  input  logic                           i_mem_rd,
  input  logic                           i_io_hold,
  output logic                           o_run_done,
  output logic                           o_code_we,
  output logic [spif_pkg::CODE_SIZE-1:0] o_code_addr,
  output spif_pkg::insn_t                o_code_wdata,
  output logic                           o_data_we,
  output logic [spif_pkg::DATA_SIZE-1:0] o_data_addr,
  output spif_pkg::word_t                o_data_wdata,
  output logic                           o_code_re,
  output logic                           o_data_re,
  output logic                           o_p_hold
);

  spif_pkg::boot_addr_t dest;              // next ram index
  spif_pkg::boot_addr_t len;               // words left minus one
  spif_pkg::word_t      word;              // word being assembled
  logic [1:0]           bytes;             // bytes per word minus one
  logic [1:0]           byte_cnt;
  logic                 run_wr;            // assembled word goes out now
  logic                 cpu_wr;            // processor code word goes out now
  logic                 boot_wr;

  assign boot_wr    = i_clear | run_wr | cpu_wr;
  assign o_p_hold   = boot_wr | i_io_hold;
  assign o_run_done = run_wr & (len == '0);

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      dest     <= '0;
      len      <= '0;
      word     <= '0;                      // zero source for the clear phase
      bytes    <= '0;
      byte_cnt <= '0;
      run_wr   <= 1'b0;
      cpu_wr   <= 1'b0;
    end else begin
      run_wr <= 1'b0;
      cpu_wr <= 1'b0;
      if (i_load_addr_hi) dest[15:8] <= i_f_din;
      if (i_load_addr_lo) dest[7:0] <= i_f_din;
      if (i_load_len_hi) len[15:8] <= i_f_din;
      if (i_load_len_lo) len[7:0] <= i_f_din;
      if (i_load_format) begin
        bytes    <= i_f_din[1:0];
        byte_cnt <= i_f_din[1:0];
      end
      if (i_shift_byte) begin
        word <= {word[spif_pkg::WIDTH-9:0], i_f_din};  // msb first
        if (byte_cnt == 2'd0) begin
          byte_cnt <= bytes;
          run_wr   <= 1'b1;
        end else begin
          byte_cnt <= byte_cnt - 2'd1;
        end
      end
      if (i_code_addr_wr) dest <= i_din[15:0];
      if (i_code_data_wr) begin
        word   <= i_din;
        cpu_wr <= 1'b1;
      end
      if (boot_wr) begin                   // bump after every steered write
        dest <= dest + 16'd1;
        word <= '0;
      end
      if (run_wr && len != '0) len <= len - 16'd1;
    end
  end

  // ==========================================================================
  // boot side steers the rams while it holds the processor
  // ==========================================================================
  assign o_code_we    = i_clear | (run_wr & (i_sink == 3'd0)) | cpu_wr;
  assign o_code_addr  = boot_wr ? dest[spif_pkg::CODE_SIZE-1:0]
                                : i_code_addr[spif_pkg::CODE_SIZE-1:0];
  assign o_code_wdata = word[15:0];
  assign o_code_re    = ~o_p_hold;

  assign o_data_we    = i_clear | (run_wr & (i_sink == 3'd1)) | (i_mem_wr & ~o_p_hold);
  assign o_data_addr  = boot_wr ? dest[spif_pkg::DATA_SIZE-1:0]
                                : i_mem_addr[spif_pkg::DATA_SIZE-1:0];
  assign o_data_wdata = boot_wr ? word : i_din;
  assign o_data_re    = i_mem_rd & ~o_p_hold;

endmodule

// File: hw/io_regs.sv
/* processor I/O registers */
module io_regs (
  input  logic               clk,
  input  logic               arstn,
  input  logic               i_io_rd,
  input  logic               i_io_wr,
  input  spif_pkg::io_addr_t i_mem_addr,
  input  spif_pkg::word_t    i_din,
  input  logic               i_p_hold,
  input  logic               i_u_ready,    // uart can take a byte
  input  logic               i_u_full,     // uart has a byte
  input  spif_pkg::byte_t    i_u_din,
  input  logic               i_booting,
  input  spif_pkg::byte_t    i_plain,      // last flash byte
  output logic               o_u_wr,
  output spif_pkg::byte_t    o_u_dout,
  output logic               o_u_rd,
  output spif_pkg::word_t    o_io_dout,
  output logic               o_io_hold,
  output logic               o_reboot,
  output logic               o_code_addr_wr,
  output logic               o_code_data_wr
);

  logic            internal;
  logic [3:0]      reg_addr;
  logic            wr_ok;                  // accepted register write
  logic            rd_ok;
  spif_pkg::byte_t rx_byte;
  logic            rx_full;

  assign internal = (i_mem_addr[14:4] == '0);
  assign reg_addr = i_mem_addr[3:0];
  assign wr_ok    = i_io_wr & internal & ~i_p_hold;
  assign rd_ok    = i_io_rd & internal & ~i_p_hold;

  // wait states while the transmitter is busy
  assign o_io_hold = i_io_wr & internal & (reg_addr == spif_pkg::REG_UART) & ~i_u_ready;

  assign o_reboot       = wr_ok & (reg_addr == spif_pkg::REG_REBOOT);
  assign o_code_addr_wr = wr_ok & (reg_addr == spif_pkg::REG_CODE_ADDR);
  assign o_code_data_wr = wr_ok & (reg_addr == spif_pkg::REG_CODE_DATA);
  assign o_u_rd         = i_u_full & ~rx_full;  // take it when the slot is empty

  // ==========================================================================
  // uart byte registers
  // ==========================================================================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      o_u_wr   <= 1'b0;
      o_u_dout <= '0;
      rx_byte  <= '0;
      rx_full  <= 1'b0;
    end else begin
      o_u_wr <= wr_ok & (reg_addr == spif_pkg::REG_UART);
      if (wr_ok && reg_addr == spif_pkg::REG_UART) begin
        o_u_dout <= i_din[7:0];
      end
      if (rd_ok && reg_addr == spif_pkg::REG_UART) begin
        rx_full <= 1'b0;                   // byte consumed
      end
      if (o_u_rd) begin
        rx_byte <= i_u_din;
        rx_full <= 1'b1;
      end
    end
  end

  // zero-extended read mux for the internal block
  always_comb begin
    o_io_dout = '0;
    if (internal) begin
      case (reg_addr)
        spif_pkg::REG_UART:      o_io_dout[7:0] = rx_byte;
        spif_pkg::REG_CODE_ADDR: o_io_dout[0] = rx_full;
        spif_pkg::REG_CODE_DATA: o_io_dout[0] = ~i_u_ready;  // tx busy
        spif_pkg::REG_REBOOT:    o_io_dout[7:0] = i_plain;
        spif_pkg::REG_BOOTING:   o_io_dout[0] = i_booting;
        default:                 o_io_dout[7:0] = o_u_dout;
      endcase
    end
  end

endmodule

// File: hw/spif_top.sv
/* serial flash boot loader */
module spif_top (
  input  logic               clk,
  input  logic               arstn,
  input  logic               i_io_rd,
  input  logic               i_io_wr,
  input  logic               i_mem_rd,
  input  logic               i_mem_wr,
  input  spif_pkg::io_addr_t i_mem_addr,
  input  spif_pkg::word_t    i_din,
  output spif_pkg::word_t    o_mem_dout,
  output spif_pkg::word_t    o_io_dout,
  input  spif_pkg::io_addr_t i_code_addr,
  output spif_pkg::insn_t    o_insn,
  output logic               o_p_hold,
  output logic               o_p_reset,
  input  logic               i_u_ready,
  output logic               o_u_wr,
  output spif_pkg::byte_t    o_u_dout,
  input  logic               i_u_full,
  output logic               o_u_rd,
  input  spif_pkg::byte_t    i_u_din,
  input  logic               i_f_ready,
  output logic               o_f_wr,
  output spif_pkg::byte_t    o_f_dout,
  output logic               o_f_cs,
  output spif_pkg::rate_t    o_f_rate,
  input  spif_pkg::byte_t    i_f_din
);

  logic                           run_done, reboot, booting, clear;
  logic                           load_addr_hi, load_addr_lo, load_len_hi, load_len_lo;
  logic                           load_format, shift_byte;
  logic [2:0]                     sink;
  logic                           code_addr_wr, code_data_wr, io_hold;
  logic                           code_we, code_re, data_we, data_re;
  logic [spif_pkg::CODE_SIZE-1:0] code_addr;
  logic [spif_pkg::DATA_SIZE-1:0] data_addr;
  spif_pkg::insn_t                code_wdata;
  spif_pkg::word_t                data_wdata;

  boot_ctrl u_ctrl (
    .clk(clk), .arstn(arstn), .i_f_ready(i_f_ready), .i_f_din(i_f_din),
    .i_run_done(run_done), .i_reboot(reboot), .o_f_wr(o_f_wr), .o_f_dout(o_f_dout),
    .o_f_cs(o_f_cs), .o_f_rate(o_f_rate), .o_p_reset(o_p_reset), .o_booting(booting),
    .o_clear(clear), .o_load_addr_hi(load_addr_hi), .o_load_addr_lo(load_addr_lo),
    .o_load_len_hi(load_len_hi), .o_load_len_lo(load_len_lo),
    .o_load_format(load_format), .o_shift_byte(shift_byte), .o_sink(sink)
  );

  boot_datapath u_dp (
    .clk(clk), .arstn(arstn), .i_clear(clear),
    .i_load_addr_hi(load_addr_hi), .i_load_addr_lo(load_addr_lo),
    .i_load_len_hi(load_len_hi), .i_load_len_lo(load_len_lo),
    .i_load_format(load_format), .i_shift_byte(shift_byte), .i_f_din(i_f_din),
    .i_sink(sink), .i_code_addr_wr(code_addr_wr), .i_code_data_wr(code_data_wr),
    .i_din(i_din), .i_code_addr(i_code_addr), .i_mem_addr(i_mem_addr),
    .i_mem_wr(i_mem_wr), .i_mem_rd(i_mem_rd), .i_io_hold(io_hold),
    .o_run_done(run_done), .o_code_we(code_we), .o_code_addr(code_addr),
    .o_code_wdata(code_wdata), .o_data_we(data_we), .o_data_addr(data_addr),
    .o_data_wdata(data_wdata), .o_code_re(code_re), .o_data_re(data_re),
    .o_p_hold(o_p_hold)
  );

  io_regs u_io (
    .clk(clk), .arstn(arstn), .i_io_rd(i_io_rd), .i_io_wr(i_io_wr),
    .i_mem_addr(i_mem_addr), .i_din(i_din), .i_p_hold(o_p_hold),
    .i_u_ready(i_u_ready), .i_u_full(i_u_full), .i_u_din(i_u_din),
    .i_booting(booting), .i_plain(i_f_din), .o_u_wr(o_u_wr), .o_u_dout(o_u_dout),
    .o_u_rd(o_u_rd), .o_io_dout(o_io_dout), .o_io_hold(io_hold), .o_reboot(reboot),
    .o_code_addr_wr(code_addr_wr), .o_code_data_wr(code_data_wr)
  );

  spram #(.ADDR_WIDTH(spif_pkg::CODE_SIZE), .DATA_WIDTH(16)) code_ram (
    .clk(clk), .i_addr(code_addr), .i_din(code_wdata), .i_we(code_we),
    .i_re(code_re), .o_dout(o_insn)
  );

  spram #(.ADDR_WIDTH(spif_pkg::DATA_SIZE), .DATA_WIDTH(spif_pkg::WIDTH)) data_ram (
    .clk(clk), .i_addr(data_addr), .i_din(data_wdata), .i_we(data_we),
    .i_re(data_re), .o_dout(o_mem_dout)
  );

endmodule

// File: test/flash_model.sv
/* SPI flash byte engine model */
module flash_model (
  input  logic            clk,
  input  logic            arstn,
  input  logic            i_wr,            // transfer request from the loader
  input  spif_pkg::byte_t i_dout,          // byte shifted out to the flash
  input  logic [3:0]      i_delay,         // extra busy cycles for a transfer
  output logic            o_ready,
  output spif_pkg::byte_t o_din            // byte clocked back
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HDR_BYTES = 5;            // opcode, 3 address, dummy
  localparam int IMG_BYTES = 25;

  spif_pkg::byte_t image [IMG_BYTES];
  spif_pkg::byte_t sent_bytes [8];         // first bytes seen on i_dout
  int              sent_cnt;
  int              reply_idx;
  int              wait_cnt;
  logic            rst_seen;
  logic            wr_seen;
  spif_pkg::byte_t dout_seen;
  logic [3:0]      delay_seen;

  // byte the flash returns for transfer number idx
  function automatic spif_pkg::byte_t reply_byte(input int idx);
    if (idx < HDR_BYTES || idx >= HDR_BYTES + IMG_BYTES) begin
      return 8'hFF;                        // bus floats during the header
    end else begin
      return image[5'(idx - HDR_BYTES)];
    end
  endfunction

  initial begin
    // boot image at the base sector
    image = '{8'h85,                           // rate 5
              8'hC1, 8'h00, 8'h10,             // address 0x0010, two bytes
              8'hC2, 8'h02,                    // length 2, low byte
              8'h01,                           // code sink, 2 bytes per word
              8'hA5, 8'h5A, 8'h12, 8'h34, 8'hBE, 8'hEF,
              8'hC0, 8'h20,                    // address 0x0020, low byte
              8'hC2, 8'h01,                    // length 1
              8'h06,                           // data sink, 3 bytes per word
              8'hFE, 8'h12, 8'h34, 8'h01, 8'hAB, 8'hCD,
              8'hE0};                          // end, processor reset released
    o_ready    = 1'b1;
    o_din      = '0;
    sent_cnt   = 0;
    reply_idx  = 0;
    wait_cnt   = 0;
    rst_seen   = 1'b1;
    wr_seen    = 1'b0;
    dout_seen  = '0;
    delay_seen = '0;
  end

  always @(negedge clk) begin
    rst_seen   = !arstn;                   // mid-cycle view of the loader
    wr_seen    = i_wr;
    dout_seen  = i_dout;
    delay_seen = i_delay;
  end

  always @(posedge clk) begin
    #1;
    if (rst_seen) begin
      o_ready  = 1'b1;
      wait_cnt = 0;
      sent_cnt = 0;
    end else if (wr_seen) begin
      if (sent_cnt < 8) begin
        sent_bytes[3'(sent_cnt)] = dout_seen;
      end
      reply_idx = sent_cnt;
      sent_cnt++;
      o_ready   = 1'b0;                    // busy until the byte is back
      wait_cnt  = int'(delay_seen);
    end else if (!o_ready) begin
      if (wait_cnt == 0) begin
        o_ready = 1'b1;
        o_din   = reply_byte(reply_idx);
      end else begin
        wait_cnt--;
      end
    end
  end

endmodule

// File: test/tb_spif.sv
/* flash loader testbench */
module tb_spif;

  timeunit 1ns;
  timeprecision 100ps;

  // image contents as laid out in the flash model
  localparam logic [15:0] CODE_W0   = 16'hA55A;
  localparam logic [15:0] CODE_W1   = 16'h1234;
  localparam logic [15:0] CODE_W2   = 16'hBEEF;
  localparam logic [23:0] DATA_RAW0 = 24'hFE1234;
  localparam logic [23:0] DATA_RAW1 = 24'h01ABCD;
  localparam int IMAGE_BYTES    = 25 + 5;  // stream plus header
  localparam int TIMEOUT_CYCLES = 2**spif_pkg::CODE_SIZE + 64 * IMAGE_BYTES + 600;

  logic               clk;
  logic               arstn;
  logic               io_rd, io_wr, mem_rd, mem_wr;
  spif_pkg::io_addr_t mem_addr, code_addr;
  spif_pkg::word_t    din, mem_dout, io_dout;
  spif_pkg::insn_t    insn;
  logic               p_hold, p_reset;
  logic               u_ready, u_wr, u_full, u_rd;
  spif_pkg::byte_t    u_dout, u_din;
  logic               f_ready, f_wr, f_cs;
  spif_pkg::byte_t    f_dout, f_din;
  spif_pkg::rate_t    f_rate;
  logic [3:0]         flash_delay;

  logic [31:0]        rng_state = 32'h7a8d;
  int                 error_cnt = 0;
  int                 cycle_cnt = 0;
  spif_pkg::byte_t    tx_byte, rx_byte;
  int                 hold_cycles;
  logic [15:0]        patch_word;

  spif_top UUT (
    .clk(clk), .arstn(arstn), .i_io_rd(io_rd), .i_io_wr(io_wr), .i_mem_rd(mem_rd),
    .i_mem_wr(mem_wr), .i_mem_addr(mem_addr), .i_din(din), .o_mem_dout(mem_dout),
    .o_io_dout(io_dout), .i_code_addr(code_addr), .o_insn(insn), .o_p_hold(p_hold),
    .o_p_reset(p_reset), .i_u_ready(u_ready), .o_u_wr(u_wr), .o_u_dout(u_dout),
    .i_u_full(u_full), .o_u_rd(u_rd), .i_u_din(u_din), .i_f_ready(f_ready),
    .o_f_wr(f_wr), .o_f_dout(f_dout), .o_f_cs(f_cs), .o_f_rate(f_rate), .i_f_din(f_din)
  );

  flash_model flash (
    .clk(clk), .arstn(arstn), .i_wr(f_wr), .i_dout(f_dout), .i_delay(flash_delay),
    .o_ready(f_ready), .o_din(f_din)
  );

  always #20 clk = ~clk;

  // ==========================================================================
  // helpers
  // ==========================================================================
  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  // low 18 bits of three bytes with the first byte most significant
  function automatic spif_pkg::word_t pack_data_word(input logic [23:0] raw);
    return raw[17:0];
  endfunction

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      error_cnt++;
      $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;                                    // drive slot after the edge
  endtask

  task automatic io_read(input logic [3:0] addr, output spif_pkg::word_t value);
    io_rd    = 1'b1;
    mem_addr = 15'(addr);
    @(negedge clk);
    while (p_hold) @(negedge clk);
    value = io_dout;                       // combinational read mux
    step();
    io_rd = 1'b0;
  endtask

  task automatic io_write(input logic [3:0] addr, input int value);
    io_wr    = 1'b1;
    mem_addr = 15'(addr);
    din      = 18'(value);
    @(negedge clk);
    while (p_hold) @(negedge clk);
    step();
    io_wr = 1'b0;
  endtask

  task automatic data_read(input int addr, output spif_pkg::word_t value);
    mem_rd   = 1'b1;
    mem_addr = 15'(addr);
    @(negedge clk);
    while (p_hold) @(negedge clk);
    step();
    mem_rd = 1'b0;
    @(negedge clk);
    value = mem_dout;
    step();
  endtask

  task automatic code_read(input int addr, output spif_pkg::insn_t value);
    code_addr = 15'(addr);
    @(negedge clk);
    while (p_hold) @(negedge clk);
    step();
    @(negedge clk);
    value = insn;
    step();
  endtask

  task automatic wait_boot_done();
    spif_pkg::word_t value;
    value = '1;
    while (value[0]) io_read(spif_pkg::REG_BOOTING, value);
  endtask

  // ==========================================================================
  // directed tests
  // ==========================================================================
  task automatic check_reset_and_header();
    spif_pkg::word_t value;
    @(negedge clk);
    check_equal(32'(f_wr), 0, "flash write idle after reset");
    check_equal(32'(u_wr), 0, "uart write idle after reset");
    check_equal(32'(u_rd), 0, "uart read idle after reset");
    check_equal(32'(p_reset), 1, "processor reset after reset");
    check_equal(32'(f_cs), 0, "chip select off during clear");
    check_equal(32'(p_hold), 1, "processor held during clear");
    step();
    while (flash.sent_cnt < 5) step();
    check_equal(32'(flash.sent_bytes[0]), 32'(spif_pkg::FAST_READ), "header opcode");
    check_equal(32'(flash.sent_bytes[1]), 32'(spif_pkg::BASEBLOCK), "header sector");
    check_equal(32'(flash.sent_bytes[2]), 0, "header address middle");
    check_equal(32'(flash.sent_bytes[3]), 0, "header address low");
    check_equal(32'(f_cs), 1, "chip select during boot");
    io_read(spif_pkg::REG_BOOTING, value);
    check_equal(32'(value), 1, "booting flag while loading");
  endtask

  task automatic check_code_image();
    spif_pkg::insn_t value;
    code_read(16'h10, value);
    check_equal(32'(value), 32'(CODE_W0), "code word 0x10");
    code_read(16'h11, value);
    check_equal(32'(value), 32'(CODE_W1), "code word 0x11");
    code_read(16'h12, value);
    check_equal(32'(value), 32'(CODE_W2), "code word 0x12");
    code_read(16'h13, value);
    check_equal(32'(value), 0, "code word past the run");
  endtask

  task automatic check_data_image();
    spif_pkg::word_t value;
    data_read(16'h20, value);
    check_equal(32'(value), 32'(pack_data_word(DATA_RAW0)), "data word 0x20");
    data_read(16'h21, value);
    check_equal(32'(value), 32'(pack_data_word(DATA_RAW1)), "data word 0x21");
    data_read(16'h22, value);
    check_equal(32'(value), 0, "data word past the run");
    data_read(16'h10, value);
    check_equal(32'(value), 0, "data cell under the code run");
  endtask

  task automatic check_boot_end();
    spif_pkg::word_t value;
    check_equal(32'(f_rate), 5, "flash divisor from the image");
    check_equal(32'(f_cs), 0, "chip select after end");
    check_equal(32'(p_reset), 0, "processor reset released");
    io_read(spif_pkg::REG_BOOTING, value);
    check_equal(32'(value), 0, "booting flag after end");
  endtask

  task automatic check_uart();
    spif_pkg::word_t value;
    u_ready  = 1'b0;                       // transmitter busy
    io_wr    = 1'b1;
    mem_addr = 15'(spif_pkg::REG_UART);
    din      = 18'(tx_byte);
    repeat (hold_cycles) begin
      @(negedge clk);
      check_equal(32'(p_hold), 1, "hold while transmitter busy");
      check_equal(32'(u_wr), 0, "no transmit while busy");
      step();
    end
    u_ready = 1'b1;
    @(negedge clk);
    check_equal(32'(p_hold), 0, "hold released with ready");
    step();
    io_wr = 1'b0;
    @(negedge clk);
    check_equal(32'(u_wr), 1, "transmit strobe");
    check_equal(32'(u_dout), 32'(tx_byte), "transmit byte");
    step();
    @(negedge clk);
    check_equal(32'(u_wr), 0, "single transmit strobe");
    step();
    u_din  = rx_byte;
    u_full = 1'b1;
    @(negedge clk);
    check_equal(32'(u_rd), 1, "receive byte taken");
    step();
    @(negedge clk);
    check_equal(32'(u_rd), 0, "no second take while the flag is set");
    step();
    u_full = 1'b0;                         // uart empty again
    io_read(spif_pkg::REG_CODE_ADDR, value);
    check_equal(32'(value), 1, "receive flag set");
    io_read(spif_pkg::REG_UART, value);
    check_equal(32'(value), 32'(rx_byte), "receive byte");
    io_read(spif_pkg::REG_CODE_ADDR, value);
    check_equal(32'(value), 0, "receive flag cleared");
  endtask

  task automatic check_code_write();
    spif_pkg::insn_t value;
    io_write(spif_pkg::REG_CODE_ADDR, 16'h40);
    io_write(spif_pkg::REG_CODE_DATA, int'(patch_word));
    code_read(16'h40, value);
    check_equal(32'(value), 32'(patch_word), "processor code write");
  endtask

  // ==========================================================================
  // run control
  // ==========================================================================
  always @(posedge clk) begin
    logic [31:0] r;
    #1;
    r = next_random();
    flash_delay = r[19:16];                // new ready delay every cycle
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Error: run timed out after %0d cycles", cycle_cnt);
      $display("Test FAILED");
      $fatal(1);
    end
  end

  initial begin
    logic [31:0] r;
    clk         = 1'b0;
    arstn       = 1'b0;
    io_rd       = 1'b0;
    io_wr       = 1'b0;
    mem_rd      = 1'b0;
    mem_wr      = 1'b0;
    mem_addr    = '0;
    code_addr   = '0;
    din         = '0;
    u_ready     = 1'b1;
    u_full      = 1'b0;
    u_din       = '0;
    flash_delay = '0;
    r           = next_random();
    tx_byte     = r[23:16];
    r           = next_random();
    rx_byte     = r[23:16];
    r           = next_random();
    hold_cycles = 1 + int'(r[17:16]);
    r           = next_random();
    patch_word  = r[31:16];
    repeat (16) @(posedge clk);
    #1 arstn = 1'b1;
    check_reset_and_header();
    wait_boot_done();
    check_code_image();
    check_data_image();
    check_boot_end();
    check_uart();
    check_code_write();
    if (error_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
hw/spif_pkg.sv
hw/spram.sv
hw/boot_ctrl.sv
hw/boot_datapath.sv
hw/io_regs.sv
hw/spif_top.sv
test/flash_model.sv
test/tb_spif.sv

// File: run.sh
#!/bin/sh
# compile and run the flash loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_spif -f build.f -o tb_spif

out=$(./obj_dir/tb_spif 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^Test OK$"; then
  exit 0
else
  exit 1
fi
